/* design/can_rx_defs.svh */
`ifndef CAN_RX_DEFS_SVH
`define CAN_RX_DEFS_SVH

// controller register port
`define CAN_RX_ADDR_W      5    // register address width
`define CAN_RX_DATA_W      16   // register data width

// message layout
`define CAN_RX_ID_W        11   // standard identifier
`define CAN_RX_NBYTES      7    // data bytes kept, slot 8 carries the bus number
`define CAN_RX_BUS_W       5    // originating bus number

// read sequence and queue sizing
`define CAN_RX_NREADS      5    // register reads per received frame
`define CAN_RX_FIFO_DEPTH  4    // power of two from 2 to 16

`endif

/* design/can_rx_pkg.sv */
`include "can_rx_defs.svh"

package can_rx_pkg;

  // receive register map of the controller
  typedef enum logic [`CAN_RX_ADDR_W-1:0] {
    REG_D7  = 5'd0,   // byte 7 in [15:8], low half unused
    REG_D56 = 5'd1,   // byte 5 high, byte 6 low
    REG_D34 = 5'd2,   // byte 3 high, byte 4 low
    REG_D12 = 5'd3,   // byte 1 high, byte 2 low
    REG_ID  = 5'd5    // identifier in [15:5]
  } can_rx_reg_e;

  // register reader sequencer
  typedef enum logic {
    IDLE = 1'b0,      // waiting for rx_irq or pending frame
    READ = 1'b1       // stepping through the register map
  } reader_state_e;

  // one returned register word, tagged
  typedef struct packed {
    can_rx_reg_e                addr;     // register the word came from
    logic [`CAN_RX_DATA_W-1:0]  data;     // raw register contents
    logic [`CAN_RX_BUS_W-1:0]   bus_sel;  // bus of the frame being read
  } rd_beat_t;

  // assembled message as seen by the host
  // data[0] is byte 1, data[6] is byte 7
  typedef struct packed {
    logic [`CAN_RX_ID_W-1:0]         id;       // 11-bit identifier
    logic [`CAN_RX_NBYTES-1:0][7:0]  data;     // payload bytes
    logic [`CAN_RX_BUS_W-1:0]        bus_sel;  // originating bus
  } can_rx_msg_t;

endpackage

/* design/rx_reg_reader.sv */
`timescale 1ns/100ps
`include "can_rx_defs.svh"

module rx_reg_reader
(
  input  logic                       clk,
  input  logic                       rst,       // sync, active low
  input  logic                       rx_irq,    // one-cycle frame received
  input  logic [`CAN_RX_BUS_W-1:0]   bus_sel,   // sampled at sequence start
  input  logic [`CAN_RX_DATA_W-1:0]  reg_data,  // registered read, one cycle after reg_rd
  output logic [`CAN_RX_ADDR_W-1:0]  reg_addr,
  output logic                       reg_rd,
  output can_rx_pkg::rd_beat_t       beat,      // returned word with its address
  output logic                       capture    // beat valid
);

  localparam int IDX_W = $clog2(`CAN_RX_NREADS);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`CAN_RX_NREADS - 1);

  can_rx_pkg::reader_state_e  state;
  logic [IDX_W-1:0]           idx;         // position in the read sequence
  logic                       pending;     // one frame waiting behind the current one
  logic [`CAN_RX_BUS_W-1:0]   bus_q;       // bus of the sequence in progress
  can_rx_pkg::can_rx_reg_e    addr_q;      // address of the read in flight
  logic [`CAN_RX_BUS_W-1:0]   beat_bus_q;  // bus paired with the read in flight
  logic                       start;
  logic                       last;

  // fixed read order, identifier first
  function automatic can_rx_pkg::can_rx_reg_e seq_addr(input logic [IDX_W-1:0] i);
    case (i)
      0:       seq_addr = can_rx_pkg::REG_ID;
      1:       seq_addr = can_rx_pkg::REG_D12;
      2:       seq_addr = can_rx_pkg::REG_D34;
      3:       seq_addr = can_rx_pkg::REG_D56;
      default: seq_addr = can_rx_pkg::REG_D7;
    endcase
  endfunction

  assign last  = (state == can_rx_pkg::READ) && (idx == LAST_IDX);  // final read this cycle
  // from idle on a new pulse or a waiting frame, back to back after the last read
  assign start = (state == can_rx_pkg::IDLE) ? (rx_irq || pending) : (last && pending);

  assign reg_rd   = (state == can_rx_pkg::READ);
  assign reg_addr = seq_addr(idx);       // rests on REG_ID while idle

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      state   <= can_rx_pkg::IDLE;
      idx     <= '0;
      pending <= 1'b0;
      capture <= 1'b0;
    end
    else
    begin
      capture <= reg_rd;                 // data comes back next cycle
      if (start)
      begin
        state   <= can_rx_pkg::READ;
        idx     <= '0;
        pending <= 1'b0;                 // waiting frame consumed, extra pulses dropped
      end
      else if (last)
      begin
        state   <= can_rx_pkg::IDLE;
        idx     <= '0;
        pending <= rx_irq;               // pulse on the final read still counts
      end
      else if (state == can_rx_pkg::READ)
      begin
        idx <= idx + 1'b1;
        if (rx_irq)
        begin
          pending <= 1'b1;               // one deep, further pulses lost
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      bus_q <= bus_sel;                  // latched per sequence
    end
    addr_q     <= seq_addr(idx);         // follows reg_addr by one cycle
    beat_bus_q <= bus_q;                 // survives a back-to-back restart
  end

  // reg_data arrives in the same cycle as the delayed address
  assign beat = '{addr: addr_q, data: reg_data, bus_sel: beat_bus_q};

endmodule

/* design/rx_msg_assembler.sv */
`timescale 1ns/100ps

module rx_msg_assembler
(
  input  logic                     clk,
  input  logic                     rst,       // sync, active low
  input  can_rx_pkg::rd_beat_t     beat,      // tagged register word
  input  logic                     capture,   // beat valid
  output can_rx_pkg::can_rx_msg_t  msg,       // message being built
  output logic                     msg_done   // msg complete, one cycle
);

  logic last_beat;

  // REG_D7 is always read last, so it closes the message
  assign last_beat = capture && (beat.addr == can_rx_pkg::REG_D7);

  // field decode by register address
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      case (beat.addr)
        can_rx_pkg::REG_ID:
        begin
          msg.id <= beat.data[15:5];        // identifier left aligned
        end
        can_rx_pkg::REG_D12:
        begin
          msg.data[0] <= beat.data[15:8];   // byte 1
          msg.data[1] <= beat.data[7:0];    // byte 2
        end
        can_rx_pkg::REG_D34:
        begin
          msg.data[2] <= beat.data[15:8];   // byte 3
          msg.data[3] <= beat.data[7:0];    // byte 4
        end
        can_rx_pkg::REG_D56:
        begin
          msg.data[4] <= beat.data[15:8];   // byte 5
          msg.data[5] <= beat.data[7:0];    // byte 6
        end
        can_rx_pkg::REG_D7:
        begin
          msg.data[6] <= beat.data[15:8];   // byte 7, low half ignored
          msg.bus_sel <= beat.bus_sel;      // bus number rides in the eighth slot
        end
        default:
        begin
        end                                 // other registers leave the message alone
      endcase
    end
  end

  // done lags the last capture by one cycle, fields settled by then
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      msg_done <= 1'b0;
    end
    else
    begin
      msg_done <= last_beat;
    end
  end

endmodule

/* design/rx_msg_fifo.sv */
`timescale 1ns/100ps
`include "can_rx_defs.svh"

module rx_msg_fifo
(
  input  logic                     clk,
  input  logic                     rst,        // sync, active low
  input  can_rx_pkg::can_rx_msg_t  msg,        // finished message
  input  logic                     msg_done,   // push strobe
  input  logic                     msg_pop,    // host strobe, ignored when empty
  output can_rx_pkg::can_rx_msg_t  msg_out,    // head entry
  output logic                     msg_avail,  // queue not empty
  output logic                     overflow    // one cycle, push dropped
);

  localparam int DEPTH = `CAN_RX_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  can_rx_pkg::can_rx_msg_t  mem [DEPTH];
  logic [PTR_W-1:0]         rd_ptr;     // head slot
  logic [PTR_W-1:0]         wr_ptr;     // next free slot
  logic [CNT_W-1:0]         count;      // entries held
  logic                     full;
  logic                     do_pop;
  logic                     do_push;

  assign full      = (count == CNT_W'(DEPTH));
  assign msg_avail = (count != '0);
  assign do_pop    = msg_pop && msg_avail;
  // a pop frees the slot in the same cycle, so full plus pop still accepts
  assign do_push   = msg_done && (!full || do_pop);

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      overflow <= msg_done && !do_push;   // message lost
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // none, or push and pop together
      endcase
    end
  end

  // storage
  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= msg;
    end
  end

  // head is visible without a read cycle, zero when empty
  assign msg_out = msg_avail ? mem[rd_ptr] : '0;

endmodule

/* design/can_rx_buffer_top.sv */
`timescale 1ns/100ps
`include "can_rx_defs.svh"

module can_rx_buffer_top
(
  input  logic                       clk,
  input  logic                       rst,        // sync, active low
  input  logic                       rx_irq,     // frame received pulse from controller
  input  logic [`CAN_RX_BUS_W-1:0]   bus_sel,    // bus the frame arrived on
  input  logic [`CAN_RX_DATA_W-1:0]  reg_data,   // controller read data
  output logic [`CAN_RX_ADDR_W-1:0]  reg_addr,   // controller register address
  output logic                       reg_rd,     // controller read strobe
  output can_rx_pkg::can_rx_msg_t    msg_out,    // oldest queued message
  output logic                       msg_avail,
  input  logic                       msg_pop,    // host takes msg_out
  output logic                       overflow    // message dropped, queue full
);

  can_rx_pkg::rd_beat_t     beat;      // reader to assembler
  logic                     capture;
  can_rx_pkg::can_rx_msg_t  msg;       // assembler to queue
  logic                     msg_done;

  // input side, register reads on rx_irq
  rx_reg_reader reader_i
  (
    .clk      (clk),
    .rst      (rst),
    .rx_irq   (rx_irq),
    .bus_sel  (bus_sel),
    .reg_data (reg_data),
    .reg_addr (reg_addr),
    .reg_rd   (reg_rd),
    .beat     (beat),
    .capture  (capture)
  );

  // field decode into one message
  rx_msg_assembler assembler_i
  (
    .clk      (clk),
    .rst      (rst),
    .beat     (beat),
    .capture  (capture),
    .msg      (msg),
    .msg_done (msg_done)
  );

  // output side, host queue
  rx_msg_fifo fifo_i
  (
    .clk       (clk),
    .rst       (rst),
    .msg       (msg),
    .msg_done  (msg_done),
    .msg_pop   (msg_pop),
    .msg_out   (msg_out),
    .msg_avail (msg_avail),
    .overflow  (overflow)
  );

endmodule

/* dv/tb_can_rx_tasks.svh */
`ifndef TB_CAN_RX_TASKS_SVH
`define TB_CAN_RX_TASKS_SVH

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// expected host message from the five register words and the frame's bus
function automatic can_rx_pkg::can_rx_msg_t expected_msg(
  input logic [`CAN_RX_DATA_W-1:0] w_id,
  input logic [`CAN_RX_DATA_W-1:0] w_d12,
  input logic [`CAN_RX_DATA_W-1:0] w_d34,
  input logic [`CAN_RX_DATA_W-1:0] w_d56,
  input logic [`CAN_RX_DATA_W-1:0] w_d7,
  input logic [`CAN_RX_BUS_W-1:0]  bus);
  can_rx_pkg::can_rx_msg_t m;
  m = '0;
  m.id      = w_id[15:5];       // identifier left aligned, low 5 bits dropped
  m.data[0] = w_d12[15:8];      // high half first
  m.data[1] = w_d12[7:0];
  m.data[2] = w_d34[15:8];
  m.data[3] = w_d34[7:0];
  m.data[4] = w_d56[15:8];
  m.data[5] = w_d56[7:0];
  m.data[6] = w_d7[15:8];       // low half of D7 unused
  m.bus_sel = bus;              // eighth byte slot
  return m;
endfunction

task automatic check_msg(input can_rx_pkg::can_rx_msg_t got, input can_rx_pkg::can_rx_msg_t exp);
  n_checks++;
  if (got !== exp)
  begin
    n_errors++;
    $display("Fail msg_out got %h expected %h", got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  n_checks++;
  if (got !== exp)
  begin
    n_errors++;
    $display("Fail %s got %h expected %h", name, got, exp);
  end
endtask

task automatic check_addr(input can_rx_pkg::can_rx_reg_e got, input can_rx_pkg::can_rx_reg_e exp);
  n_checks++;
  if (got !== exp)
  begin
    n_errors++;
    $display("Fail reg_addr got %h expected %h", got, exp);
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  n_checks++;
  if (got != exp)
  begin
    n_errors++;
    $display("Fail %s got %h expected %h", name, got, exp);
  end
endtask

`endif

/* dv/tb_can_rx_buffer.sv */
`timescale 1ns/100ps
`include "can_rx_defs.svh"

module tb_can_rx_buffer;

  localparam int DEPTH    = `CAN_RX_FIFO_DEPTH;
  localparam int N_FRAMES = 1 + 3 + 5 + 40;          // pulses sent over all tests
  localparam int MAX_CYC  = 20 * N_FRAMES + 200;

  // frame still inside the DUT, with the edge where the queue sees it
  typedef struct packed {
    int                       done_edge;
    can_rx_pkg::can_rx_msg_t  msg;
  } frame_t;

  logic                             clk;
  logic                             rst;
  logic                             rx_irq;
  logic [`CAN_RX_BUS_W-1:0]         bus_sel;
  logic [`CAN_RX_DATA_W-1:0]        reg_data;
  logic [`CAN_RX_ADDR_W-1:0]        reg_addr;
  logic                             reg_rd;
  can_rx_pkg::can_rx_msg_t          msg_out;
  logic                             msg_avail;
  logic                             msg_pop;
  logic                             overflow;

  int                               n_errors;
  int                               n_checks;
  int                               n_ovf;              // overflow pulses seen
  int                               n_pops;             // messages taken
  int                               cyc;                // posedges since start
  int                               pop_mode;           // 0 none, 1 random, 2 always
  int                               t_drive;
  int                               base;
  logic [31:0]                      rng_stim;
  logic [31:0]                      rng_pop;
  logic [`CAN_RX_DATA_W-1:0]        regs [5];           // index 4 is REG_ID
  logic                             rd_q;               // controller read register
  logic [`CAN_RX_ADDR_W-1:0]        raddr_q;
  frame_t                           inflight [$];
  can_rx_pkg::can_rx_msg_t          exp_q [$];          // expected queue contents
  can_rx_pkg::can_rx_reg_e          seq [5] = '{can_rx_pkg::REG_ID, can_rx_pkg::REG_D12,
                                                can_rx_pkg::REG_D34, can_rx_pkg::REG_D56,
                                                can_rx_pkg::REG_D7};

  `include "tb_can_rx_tasks.svh"

  can_rx_buffer_top dut_i
  (
    .clk       (clk),
    .rst       (rst),
    .rx_irq    (rx_irq),
    .bus_sel   (bus_sel),
    .reg_data  (reg_data),
    .reg_addr  (reg_addr),
    .reg_rd    (reg_rd),
    .msg_out   (msg_out),
    .msg_avail (msg_avail),
    .msg_pop   (msg_pop),
    .overflow  (overflow)
  );

  always #10 clk = ~clk;

  function automatic int reg_index(input logic [`CAN_RX_ADDR_W-1:0] a);
    return (a == 5'd5) ? 4 : int'(a);      // REG_ID packed into slot 4
  endfunction

  // controller register file, registered read
  always @(posedge clk)
  begin
    rd_q    <= reg_rd;
    raddr_q <= reg_addr;
  end

  always @(negedge clk)
  begin
    if (rd_q)
    begin
      reg_data = regs[reg_index(raddr_q)];  // word of the previous cycle's read
    end
  end

  // cycle counter and run limit
  always @(posedge clk)
  begin
    cyc = cyc + 1;
    if (cyc >= MAX_CYC)
    begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // scoreboard with queue model, overflow and avail checks, host pops
  always @(negedge clk)
  begin
    logic ovf_exp;
    logic do_pop;
    ovf_exp = 1'b0;
    do_pop  = 1'b0;
    if (rst)
    begin
      while (inflight.size() > 0 && inflight[0].done_edge == cyc)
      begin
        if (exp_q.size() == DEPTH)
        begin
          ovf_exp = 1'b1;                   // dropped
        end
        else
        begin
          exp_q.push_back(inflight[0].msg);
        end
        void'(inflight.pop_front());
      end
      check_bit("overflow", overflow, ovf_exp);
      check_bit("msg_avail", msg_avail, exp_q.size() != 0);
      if (overflow)
      begin
        n_ovf++;
        if (exp_q.size() != DEPTH)
        begin
          n_errors++;
          $display("overflow without full queue");
        end
      end
      rng_pop = xorshift32(rng_pop);
      // sparse random pops let the queue fill and overflow
      do_pop  = (pop_mode == 2) || (pop_mode == 1 && rng_pop[3:0] == 4'h0);
      if (do_pop && msg_avail && exp_q.size() > 0)
      begin
        check_msg(msg_out, exp_q[0]);       // head before it leaves
        void'(exp_q.pop_front());
        n_pops++;
      end
    end
    msg_pop = do_pop;                       // ignored by DUT when empty
  end

  task automatic fill_regs();
    for (int i = 0; i < 5; i++)
    begin
      rng_stim = xorshift32(rng_stim);
      regs[i]  = rng_stim[31:16] ^ rng_stim[15:0];
    end
  endtask

  // called at a falling edge, returns one cycle later with rx_irq low
  task automatic send_frame(input logic [`CAN_RX_BUS_W-1:0] bus);
    fill_regs();
    bus_sel = bus;
    rx_irq  = 1'b1;
    inflight.push_back('{done_edge: cyc + 8,
                         msg: expected_msg(regs[4], regs[3], regs[2], regs[1], regs[0], bus)});
    @(negedge clk);
    rx_irq = 1'b0;
  endtask

  task automatic drain_queue();
    int n;
    n = 0;
    pop_mode = 2;
    while ((exp_q.size() != 0 || inflight.size() != 0 || msg_avail) && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    if (n >= 100)
    begin
      n_errors++;
      $display("queue did not drain after 100 cycles of pops");
    end
    pop_mode = 0;
    @(negedge clk);
  endtask

  initial
  begin
    clk      = 1'b0;
    rst      = 1'b0;
    rx_irq   = 1'b0;
    bus_sel  = '0;
    reg_data = '0;
    msg_pop  = 1'b0;
    n_errors = 0;
    n_checks = 0;
    n_ovf    = 0;
    n_pops   = 0;
    cyc      = 0;
    pop_mode = 0;
    rng_stim = 32'hc9bc8633;
    rng_pop  = xorshift32(32'hc9bc8633);
    fill_regs();
    repeat (5) @(negedge clk);
    rst = 1'b1;

    // idle state after reset
    @(negedge clk);
    check_bit("msg_avail", msg_avail, 1'b0);
    check_bit("overflow", overflow, 1'b0);
    check_bit("reg_rd", reg_rd, 1'b0);
    check_msg(msg_out, '0);

    // single frame, read order and latency
    t_drive = cyc;
    send_frame(5'h0b);
    for (int i = 0; i < 5; i++)
    begin
      check_bit("reg_rd", reg_rd, 1'b1);
      check_addr(can_rx_pkg::can_rx_reg_e'(reg_addr), seq[i]);
      @(negedge clk);
    end
    check_bit("reg_rd", reg_rd, 1'b0);
    while (!msg_avail && cyc - t_drive < 20)
    begin
      @(negedge clk);
    end
    check_count("latency", cyc - t_drive, 8);
    drain_queue();

    // pending pulse kept, third pulse lost
    base = n_pops;
    send_frame(5'h03);
    rx_irq = 1'b1;                          // sets pending
    @(negedge clk);
    rx_irq = 1'b1;                          // pending already set
    @(negedge clk);
    rx_irq = 1'b0;
    @(negedge clk);
    bus_sel = 5'h1c;                        // sampled when the second read starts
    inflight.push_back('{done_edge: cyc + 9,
                         msg: expected_msg(regs[4], regs[3], regs[2], regs[1], regs[0], 5'h1c)});
    repeat (15) @(negedge clk);
    drain_queue();
    check_count("pending_msgs", n_pops - base, 2);

    // fill the queue, fifth frame overflows
    base = n_ovf;
    for (int i = 0; i < 5; i++)
    begin
      rng_stim = xorshift32(rng_stim);
      send_frame(rng_stim[4:0]);
      repeat (8) @(negedge clk);
    end
    repeat (4) @(negedge clk);
    check_count("overflow_pulses", n_ovf - base, 1);
    drain_queue();
    check_bit("msg_avail", msg_avail, 1'b0);

    // random traffic with random pops
    pop_mode = 1;
    for (int i = 0; i < 40; i++)
    begin
      rng_stim = xorshift32(rng_stim);
      send_frame(rng_stim[4:0]);
      repeat (8 + rng_stim[10:8] % 5) @(negedge clk);
    end
    repeat (10) @(negedge clk);
    drain_queue();

    if (exp_q.size() != 0 || inflight.size() != 0)
    begin
      n_errors++;
      $display("expected messages left over at end of run");
    end
    $display("checks %0d, pops %0d, overflows %0d, errors %0d", n_checks, n_pops, n_ovf, n_errors);
    if (n_errors == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* can_rx_buffer.f */
+incdir+design
+incdir+dv
design/can_rx_pkg.sv
design/rx_reg_reader.sv
design/rx_msg_assembler.sv
design/rx_msg_fifo.sv
design/can_rx_buffer_top.sv
dv/tb_can_rx_buffer.sv
